// ==== hw/zx_cfg.svh ====
`ifndef ZX_CFG_SVH
`define ZX_CFG_SVH

// dram word address is the page number followed by the word offset in page
`define ZX_DRAM_AW 17
`define ZX_PAGE_BITS 4

// video output buffer, in words
`define ZX_VBUF_DEPTH 4

// 6912 bytes of pixels and attributes
`define ZX_SCREEN_WORDS 3456

`endif

// ==== hw/zx_pkg.sv ====
`include "zx_cfg.svh"

package zx_pkg;

	// page number as held in the paging registers
	typedef logic [7:0] page_t;

	typedef logic [`ZX_DRAM_AW-1:0] dram_addr_t;

	typedef logic [15:0] dram_word_t;

	// bit 0 selects the low byte
	typedef logic [1:0] bsel_t;

endpackage

// ==== hw/page_regs.sv ====
`timescale 1ns/1ps

module page_regs (
	input  logic          fclk,
	input  logic          arst_n,
	input  logic          port_wr,
	input  logic [15:0]   port_adr,
	input  logic [7:0]    port_dat,
	output zx_pkg::page_t p7ffd,
	output zx_pkg::page_t peff7
);

	logic hit_7ffd;
	logic hit_eff7;

	// partial decode on low a15 and a1
	assign hit_7ffd = port_wr && !port_adr[15] && !port_adr[1];
	assign hit_eff7 = port_wr && (port_adr == 16'hEFF7);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			p7ffd <= '0;
			peff7 <= '0;
		end
		else
		begin
			// bit 5 freezes 7ffd until the next reset
			if (hit_7ffd && !p7ffd[5])
				p7ffd <= port_dat;
			if (hit_eff7)
				peff7 <= port_dat;
		end
	end

endmodule

// ==== hw/zmem.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module zmem (
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               cpu_cyc,
	input  logic               cpu_stb,
	input  logic               cpu_we,
	input  logic               cpu_io,
	input  logic [15:0]        cpu_adr,
	input  logic [7:0]         cpu_dat_w,
	output logic [7:0]         cpu_dat_r,
	output logic               cpu_ack,
	output logic               port_wr,
	output logic [15:0]        port_adr,
	output logic [7:0]         port_dat,
	input  zx_pkg::page_t      p7ffd,
	input  zx_pkg::page_t      peff7,
	output logic               cpu_req,
	output logic               cpu_rnw,
	output zx_pkg::dram_addr_t cpu_addr,
	output zx_pkg::bsel_t      cpu_bsel,
	output zx_pkg::dram_word_t cpu_wrdata,
	input  logic               cpu_strobe,
	input  zx_pkg::dram_word_t cpu_rddata
);

	logic          start;
	logic          rom_wr;
	zx_pkg::page_t page;

	// new cycle only once the previous one is fully closed
	assign start = cpu_cyc && cpu_stb && !cpu_ack && !cpu_req;
	assign rom_wr = cpu_we && (cpu_adr[15:14] == 2'd0) && !peff7[3];

	always_comb
	begin
		case (cpu_adr[15:14])
			2'd0: page = peff7[3] ? 8'd0 : 8'd8 + {7'd0, p7ffd[4]};
			2'd1: page = 8'd5;
			2'd2: page = 8'd2;
			default: page = {5'd0, p7ffd[2:0]};
		endcase
	end

	assign cpu_addr = {page[`ZX_PAGE_BITS-1:0], cpu_adr[13:1]};
	assign cpu_bsel = cpu_adr[0] ? 2'b10 : 2'b01;
	assign cpu_wrdata = {cpu_dat_w, cpu_dat_w};
	assign cpu_rnw = !cpu_we;

	assign port_adr = cpu_adr;
	assign port_dat = cpu_dat_w;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cpu_ack <= 1'b0;
			cpu_req <= 1'b0;
			port_wr <= 1'b0;
		end
		else
		begin
			cpu_ack <= 1'b0;
			port_wr <= 1'b0;
			// io and rom writes never touch dram
			if (start && (cpu_io || rom_wr))
			begin
				cpu_ack <= 1'b1;
				port_wr <= cpu_io && cpu_we;
			end
			else if (start)
				cpu_req <= 1'b1;
			else if (cpu_req && cpu_strobe)
			begin
				cpu_req <= 1'b0;
				cpu_ack <= 1'b1;
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (start && cpu_io)
			cpu_dat_r <= 8'hFF;
		else if (cpu_req && cpu_strobe)
			cpu_dat_r <= cpu_adr[0] ? cpu_rddata[15:8] : cpu_rddata[7:0];
	end

endmodule

// ==== hw/arbiter.sv ====
`timescale 1ns/1ps

module arbiter (
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               cpu_req,
	input  logic               cpu_rnw,
	input  zx_pkg::dram_addr_t cpu_addr,
	input  zx_pkg::bsel_t      cpu_bsel,
	input  zx_pkg::dram_word_t cpu_wrdata,
	output logic               cpu_strobe,
	output zx_pkg::dram_word_t cpu_rddata,
	input  logic               video_req,
	input  zx_pkg::dram_addr_t video_addr,
	output logic               video_next,
	output logic               video_strobe,
	output zx_pkg::dram_word_t video_data,
	output logic               dram_req,
	output logic               dram_rnw,
	output zx_pkg::dram_addr_t dram_addr,
	output zx_pkg::bsel_t      dram_bsel,
	output zx_pkg::dram_word_t dram_wrdata,
	input  logic               cbeg,
	input  logic               rrdy,
	input  zx_pkg::dram_word_t rddata
);

	logic       take;
	logic       busy;
	logic       own_video;
	logic       own_rnw;
	logic [1:0] age;
	logic       done;

	// video has priority in every slot
	assign take = cbeg && !busy && (video_req || cpu_req);
	assign video_next = take && video_req;

	assign dram_req = take;
	assign dram_rnw = video_req || cpu_rnw;
	assign dram_addr = video_req ? video_addr : cpu_addr;
	assign dram_bsel = video_req ? 2'b11 : cpu_bsel;
	assign dram_wrdata = cpu_wrdata;

	// reads end on rrdy, writes on slot 3 by count
	assign done = busy && (own_rnw ? rrdy : (age == 2'd2));
	assign cpu_strobe = done && !own_video;
	assign video_strobe = done && own_video;
	assign cpu_rddata = rddata;
	assign video_data = rddata;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			own_video <= 1'b0;
			own_rnw <= 1'b0;
			age <= 2'd0;
		end
		else if (take)
		begin
			busy <= 1'b1;
			own_video <= video_req;
			own_rnw <= dram_rnw;
			age <= 2'd0;
		end
		else if (done)
			busy <= 1'b0;
		else if (busy)
			age <= age + 2'd1;
	end

endmodule

// ==== hw/dram_store.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module dram_store (
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               dram_req,
	input  logic               dram_rnw,
	input  zx_pkg::dram_addr_t dram_addr,
	input  zx_pkg::bsel_t      dram_bsel,
	input  zx_pkg::dram_word_t dram_wrdata,
	output logic               cbeg,
	output logic               rrdy,
	output zx_pkg::dram_word_t rddata
);

	logic [1:0]         slot;
	logic [1:0]         rd_pipe;
	zx_pkg::dram_addr_t rd_addr;
	zx_pkg::dram_word_t mem [0:(1 << `ZX_DRAM_AW) - 1];

	assign cbeg = (slot == 2'd0);

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			slot <= 2'd0;
			rd_pipe <= 2'd0;
			rrdy <= 1'b0;
		end
		else
		begin
			slot <= slot + 2'd1;
			rd_pipe <= {rd_pipe[0], cbeg && dram_req && dram_rnw};
			rrdy <= rd_pipe[1];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (cbeg && dram_req && dram_rnw)
			rd_addr <= dram_addr;
		if (cbeg && dram_req && !dram_rnw)
		begin
			if (dram_bsel[0])
				mem[dram_addr][7:0] <= dram_wrdata[7:0];
			if (dram_bsel[1])
				mem[dram_addr][15:8] <= dram_wrdata[15:8];
		end
		// data lands together with rrdy
		if (rd_pipe[1])
			rddata <= mem[rd_addr];
	end

endmodule

// ==== hw/vfetch.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module vfetch (
	input  logic               fclk,
	input  logic               arst_n,
	input  zx_pkg::page_t      p7ffd,
	input  logic               vid_frame,
	input  logic               vid_next,
	output logic               vid_valid,
	output zx_pkg::dram_word_t vid_data,
	output logic               video_req,
	output zx_pkg::dram_addr_t video_addr,
	input  logic               video_next,
	input  logic               video_strobe,
	input  zx_pkg::dram_word_t video_data
);

	localparam int OW = `ZX_DRAM_AW - `ZX_PAGE_BITS;
	localparam int PW = $clog2(`ZX_VBUF_DEPTH);
	localparam int CW = $clog2(`ZX_VBUF_DEPTH + 1);

	zx_pkg::dram_word_t fifo [0:`ZX_VBUF_DEPTH-1];
	logic [PW-1:0]      wr_ptr;
	logic [PW-1:0]      rd_ptr;
	logic [CW-1:0]      count;
	logic [OW-1:0]      woff;
	logic               scr;
	logic               inflight;
	logic               drop;
	logic               push;
	logic               pop;
	zx_pkg::page_t      vpage;

	assign vpage = scr ? 8'd7 : 8'd5;
	assign video_addr = {vpage[`ZX_PAGE_BITS-1:0], woff};

	// words granted before a frame pulse are thrown away
	assign push = video_strobe && !drop && !vid_frame;
	assign pop = vid_next && vid_valid && !vid_frame;
	assign vid_valid = (count != '0);
	assign vid_data = fifo[rd_ptr];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			video_req <= 1'b0;
			inflight <= 1'b0;
			drop <= 1'b0;
			woff <= '0;
			scr <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// in-flight word counts as occupied
			video_req <= (count + CW'(inflight)) < CW'(`ZX_VBUF_DEPTH);
			if (video_next)
				inflight <= 1'b1;
			else if (video_strobe)
				inflight <= 1'b0;
			if (vid_frame)
			begin
				drop <= (inflight && !video_strobe) || video_next;
				woff <= '0;
				scr <= p7ffd[3];
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (video_strobe)
					drop <= 1'b0;
				if (video_next)
				begin
					woff <= (woff == OW'(`ZX_SCREEN_WORDS - 1)) ? '0 : woff + 1'b1;
					scr <= p7ffd[3];
				end
				// pointers wrap at the power-of-two depth
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + CW'(push) - CW'(pop);
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (push)
			fifo[wr_ptr] <= video_data;
	end

endmodule

// ==== hw/zx_mem_top.sv ====
`timescale 1ns/1ps

module zx_mem_top (
	input  logic               fclk,
	input  logic               arst_n,
	input  logic               cpu_cyc,
	input  logic               cpu_stb,
	input  logic               cpu_we,
	input  logic               cpu_io,
	input  logic [15:0]        cpu_adr,
	input  logic [7:0]         cpu_dat_w,
	output logic [7:0]         cpu_dat_r,
	output logic               cpu_ack,
	input  logic               vid_frame,
	input  logic               vid_next,
	output logic               vid_valid,
	output zx_pkg::dram_word_t vid_data
);

	logic               port_wr;
	logic [15:0]        port_adr;
	logic [7:0]         port_dat;
	zx_pkg::page_t      p7ffd;
	zx_pkg::page_t      peff7;

	logic               cpu_req;
	logic               cpu_rnw;
	zx_pkg::dram_addr_t cpu_addr;
	zx_pkg::bsel_t      cpu_bsel;
	zx_pkg::dram_word_t cpu_wrdata;
	logic               cpu_strobe;
	zx_pkg::dram_word_t cpu_rddata;

	logic               video_req;
	zx_pkg::dram_addr_t video_addr;
	logic               video_next;
	logic               video_strobe;
	zx_pkg::dram_word_t video_data;

	logic               dram_req;
	logic               dram_rnw;
	zx_pkg::dram_addr_t dram_addr;
	zx_pkg::bsel_t      dram_bsel;
	zx_pkg::dram_word_t dram_wrdata;
	logic               cbeg;
	logic               rrdy;
	zx_pkg::dram_word_t rddata;

	page_regs u_page_regs (
		.fclk(fclk), .arst_n(arst_n),
		.port_wr(port_wr), .port_adr(port_adr), .port_dat(port_dat),
		.p7ffd(p7ffd), .peff7(peff7)
	);

	zmem u_zmem (
		.fclk(fclk), .arst_n(arst_n),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_io(cpu_io),
		.cpu_adr(cpu_adr), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
		.port_wr(port_wr), .port_adr(port_adr), .port_dat(port_dat),
		.p7ffd(p7ffd), .peff7(peff7),
		.cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_addr(cpu_addr), .cpu_bsel(cpu_bsel),
		.cpu_wrdata(cpu_wrdata), .cpu_strobe(cpu_strobe), .cpu_rddata(cpu_rddata)
	);

	arbiter u_arbiter (
		.fclk(fclk), .arst_n(arst_n),
		.cpu_req(cpu_req), .cpu_rnw(cpu_rnw), .cpu_addr(cpu_addr), .cpu_bsel(cpu_bsel),
		.cpu_wrdata(cpu_wrdata), .cpu_strobe(cpu_strobe), .cpu_rddata(cpu_rddata),
		.video_req(video_req), .video_addr(video_addr), .video_next(video_next),
		.video_strobe(video_strobe), .video_data(video_data),
		.dram_req(dram_req), .dram_rnw(dram_rnw), .dram_addr(dram_addr),
		.dram_bsel(dram_bsel), .dram_wrdata(dram_wrdata),
		.cbeg(cbeg), .rrdy(rrdy), .rddata(rddata)
	);

	dram_store u_dram_store (
		.fclk(fclk), .arst_n(arst_n),
		.dram_req(dram_req), .dram_rnw(dram_rnw), .dram_addr(dram_addr),
		.dram_bsel(dram_bsel), .dram_wrdata(dram_wrdata),
		.cbeg(cbeg), .rrdy(rrdy), .rddata(rddata)
	);

	vfetch u_vfetch (
		.fclk(fclk), .arst_n(arst_n), .p7ffd(p7ffd),
		.vid_frame(vid_frame), .vid_next(vid_next), .vid_valid(vid_valid), .vid_data(vid_data),
		.video_req(video_req), .video_addr(video_addr), .video_next(video_next),
		.video_strobe(video_strobe), .video_data(video_data)
	);

endmodule

// ==== tb/zx_mem_props.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module zx_mem_props (
	input logic                                  fclk,
	input logic                                  arst_n,
	input logic                                  cpu_cyc,
	input logic                                  cpu_stb,
	input logic                                  cpu_ack,
	input logic                                  cbeg,
	input logic                                  dram_req,
	input logic                                  dram_rnw,
	input logic                                  rrdy,
	input logic [$clog2(`ZX_VBUF_DEPTH + 1)-1:0] vbuf_count
);

	int fails;

	initial
		fails = 0;

	// ack only inside an open strobe
	ack_in_cycle: assert property (@(posedge fclk) disable iff (!arst_n)
		cpu_ack |-> (cpu_cyc && cpu_stb))
	else
	begin
		fails++;
		$error("cpu_ack high without cpu_cyc and cpu_stb");
	end

	ack_pulse: assert property (@(posedge fclk) disable iff (!arst_n)
		cpu_ack |=> !cpu_ack)
	else
	begin
		fails++;
		$error("cpu_ack held for more than one cycle");
	end

	// read taken in slot 0 returns in slot 3
	rrdy_after_read: assert property (@(posedge fclk) disable iff (!arst_n)
		(cbeg && dram_req && dram_rnw) |-> ##3 rrdy)
	else
	begin
		fails++;
		$error("rrdy missing 3 cycles after a read was taken");
	end

	rrdy_has_read: assert property (@(posedge fclk) disable iff (!arst_n)
		rrdy |-> $past(cbeg && dram_req && dram_rnw, 3))
	else
	begin
		fails++;
		$error("rrdy without a read taken 3 cycles before");
	end

	vbuf_no_overflow: assert property (@(posedge fclk) disable iff (!arst_n)
		vbuf_count <= `ZX_VBUF_DEPTH)
	else
	begin
		fails++;
		$error("video buffer holds more words than its depth");
	end

endmodule

bind zx_mem_top zx_mem_props u_props (
	.fclk(fclk),
	.arst_n(arst_n),
	.cpu_cyc(cpu_cyc),
	.cpu_stb(cpu_stb),
	.cpu_ack(cpu_ack),
	.cbeg(cbeg),
	.dram_req(dram_req),
	.dram_rnw(dram_rnw),
	.rrdy(rrdy),
	.vbuf_count(u_vfetch.count)
);

// ==== tb/tb_zx_mem.sv ====
`timescale 1ns/1ps
`include "zx_cfg.svh"

module tb_zx_mem;

	localparam int ACK_LIMIT = 200;
	localparam int VID_LIMIT = 200;
	localparam int SETTLE = 40;

	logic        fclk;
	logic        arst_n;
	logic        cpu_cyc;
	logic        cpu_stb;
	logic        cpu_we;
	logic        cpu_io;
	logic [15:0] cpu_adr;
	logic [7:0]  cpu_dat_w;
	logic [7:0]  cpu_dat_r;
	logic        cpu_ack;
	logic        vid_frame;
	logic        vid_next;
	logic        vid_valid;
	logic [15:0] vid_data;

	// byte image of the whole store by word address then lane
	logic [7:0]  mirror [0:(1 << (`ZX_DRAM_AW + 1)) - 1];
	logic [7:0]  m7ffd;
	logic [7:0]  meff7;
	logic [3:0]  vpage;
	int          voff;
	logic        vmode;
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	logic        timed_out;

	zx_mem_top dut (
		.fclk(fclk), .arst_n(arst_n),
		.cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_io(cpu_io),
		.cpu_adr(cpu_adr), .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
		.vid_frame(vid_frame), .vid_next(vid_next), .vid_valid(vid_valid), .vid_data(vid_data)
	);

	initial
	begin
		fclk = 1'b0;
		forever
			#50 fclk = ~fclk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr_step(lfsr);
		return b;
	endfunction

	// every address bit shows up in the word
	function automatic logic [15:0] fill_word(input logic [16:0] a);
		return {3'b101, a[12:8], a[7:0] ^ {a[16:13], 4'h0}};
	endfunction

	function automatic logic rom_window(input logic [15:0] adr);
		return (adr[15:14] == 2'd0) && !meff7[3];
	endfunction

	function automatic logic [17:0] byte_index(input logic [15:0] adr);
		logic [3:0] pg;
		case (adr[15:14])
			2'd0: pg = meff7[3] ? 4'd0 : (m7ffd[4] ? 4'd9 : 4'd8);
			2'd1: pg = 4'd5;
			2'd2: pg = 4'd2;
			default: pg = {1'b0, m7ffd[2:0]};
		endcase
		return {pg, adr[13:0]};
	endfunction

	task automatic preload();
		logic [15:0] w;
		for (int a = 0; a < (1 << `ZX_DRAM_AW); a++)
		begin
			w = fill_word(17'(a));
			dut.u_dram_store.mem[a] = w;
			mirror[2 * a] = w[7:0];
			mirror[2 * a + 1] = w[15:8];
		end
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s gave %h, expected %h", $time, what, got, want);
		end
	endtask

	// sparse pops in random mode so the buffer still fills
	task automatic clock_step();
		logic b;
		@(posedge fclk);
		if (vmode)
		begin
			b = rand_bit();
			b = rand_bit() & b;
			b = rand_bit() & b;
			vid_next <= b;
		end
		else
			vid_next <= 1'b0;
	endtask

	task automatic settle();
		repeat (SETTLE)
		begin
			@(posedge fclk);
			vid_next <= 1'b0;
		end
	endtask

	task automatic idle_gap();
		logic [1:0] n;
		n[1] = rand_bit();
		n[0] = rand_bit();
		repeat (n)
			clock_step();
	endtask

	task automatic cpu_cycle(input logic we, input logic io, input logic [15:0] adr,
		input logic [7:0] dat, output logic [7:0] rd, output int lat);
		int n;
		n = 0;
		rd = 8'h00;
		lat = 0;
		clock_step();
		cpu_cyc <= 1'b1;
		cpu_stb <= 1'b1;
		cpu_we <= we;
		cpu_io <= io;
		cpu_adr <= adr;
		cpu_dat_w <= dat;
		while (lat == 0 && !timed_out)
		begin
			clock_step();
			n++;
			@(negedge fclk);
			if (cpu_ack)
			begin
				lat = n;
				rd = cpu_dat_r;
			end
			else if (n >= ACK_LIMIT)
			begin
				timed_out = 1'b1;
				errors++;
				$display("no cpu_ack within %0d cycles for address %h at %0t", n, adr, $time);
			end
		end
		clock_step();
		cpu_cyc <= 1'b0;
		cpu_stb <= 1'b0;
	endtask

	task automatic pulse_frame();
		@(posedge fclk);
		vid_frame <= 1'b1;
		vid_next <= 1'b0;
		@(posedge fclk);
		vid_frame <= 1'b0;
		vpage = m7ffd[3] ? 4'd7 : 4'd5;
		voff = 0;
		settle();
	endtask

	task automatic check_video(input int words);
		int          got;
		int          idle;
		logic [17:0] bi;
		got = 0;
		idle = 0;
		while (got < words && !timed_out)
		begin
			@(posedge fclk);
			vid_next <= rand_bit();
			@(negedge fclk);
			if (vid_next && vid_valid)
			begin
				bi = {vpage, voff[12:0], 1'b0};
				check_value($sformatf("video word %0d of page %0d", voff, vpage), vid_data,
					{mirror[bi + 1], mirror[bi]});
				voff = (voff == `ZX_SCREEN_WORDS - 1) ? 0 : voff + 1;
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle >= VID_LIMIT)
				begin
					timed_out = 1'b1;
					errors++;
					$display("no video word within %0d cycles at %0t", idle, $time);
				end
			end
		end
		settle();
	endtask

	task automatic run_case(input logic [3:0] op, input logic [15:0] adr,
		input logic [7:0] dat, input logic [7:0] exp);
		logic [7:0]  rd;
		int          lat;
		logic [17:0] bi;
		bi = byte_index(adr);
		case (op)
			4'h0, 4'h1:
			begin
				cpu_cycle(op == 4'h0, 1'b0, adr, dat, rd, lat);
				if (op == 4'h0 && !rom_window(adr))
					mirror[bi] = dat;
				if (op == 4'h1 && lat > 0)
				begin
					check_value($sformatf("memory read %h", adr), rd, mirror[bi]);
					check_value($sformatf("memory read %h, case file", adr), rd, exp);
				end
				// buffer is full while vid_next stays low
				if (!vmode && lat > 0)
					check_value($sformatf("ack within 9 cycles at %h", adr), lat <= 9, 1);
				idle_gap();
			end
			4'h2, 4'h3:
			begin
				cpu_cycle(op == 4'h2, 1'b1, adr, dat, rd, lat);
				if (op == 4'h2 && !adr[15] && !adr[1] && !m7ffd[5])
					m7ffd = dat;
				if (op == 4'h2 && adr == 16'hEFF7)
					meff7 = dat;
				if (op == 4'h3 && lat > 0)
				begin
					check_value($sformatf("io read %h", adr), rd, 8'hFF);
					check_value($sformatf("io read %h, case file", adr), rd, exp);
				end
				if (lat > 0)
					check_value($sformatf("io ack delay at %h", adr), lat, 1);
				idle_gap();
			end
			4'h4: check_video(adr);
			4'h5: pulse_frame();
			4'h6:
			begin
				vmode = 1'b0;
				settle();
			end
			4'h7: vmode = 1'b1;
			default:
			begin
				errors++;
				$display("unknown opcode %h in the case file", op);
			end
		endcase
	endtask

	initial
	begin
		int          fd;
		int          rc;
		string       line;
		logic [31:0] op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
		arst_n = 1'b0;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_io = 1'b0;
		cpu_adr = 16'h0000;
		cpu_dat_w = 8'h00;
		vid_frame = 1'b0;
		vid_next = 1'b0;
		lfsr = 32'h14e8_11e9;
		m7ffd = 8'h00;
		meff7 = 8'h00;
		vpage = 4'd5;
		voff = 0;
		vmode = 1'b0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		preload();
		repeat (3)
			@(posedge fclk);
		arst_n <= 1'b1;
		settle();
		fd = $fopen("tb/mem_cases.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("cannot open tb/mem_cases.txt");
		end
		else
		begin
			while (!$feof(fd) && !timed_out)
			begin
				rc = $fgets(line, fd);
				if (rc > 0 && line.getc(0) != "#")
				begin
					rc = $sscanf(line, "%h %h %h %h", op, adr, dat, exp);
					if (rc == 4)
						run_case(op[3:0], adr[15:0], dat[7:0], exp[7:0]);
				end
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, dut.u_props.fails);
		if (errors == 0 && dut.u_props.fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tb/mem_cases.txt ====
# op address data expected, all hex
# op 0 mem write, 1 mem read, 2 io write, 3 io read, 4 video words, 5 frame, 6 vid_next low, 7 vid_next random
6 0000 00 00
0 4000 11 00
0 4001 22 00
0 8000 33 00
0 c123 44 00
1 4000 00 11
1 4001 00 22
1 8000 00 33
1 c123 00 44
1 0000 00 80
0 0000 55 00
1 0000 00 80
1 0001 00 a0
2 7ffd 05 00
0 c002 66 00
1 4002 00 66
2 7ffd 02 00
0 c003 77 00
1 8003 00 77
1 c000 00 33
2 7ffd 12 00
1 0010 00 98
1 0000 00 90
2 eff7 08 00
0 0005 9a 00
1 0005 00 9a
1 0123 00 44
2 7ffd 10 00
1 c005 00 9a
2 eff7 00 00
1 0000 00 90
3 eff7 00 ff
7 0000 00 00
0 4003 5e 00
1 4003 00 5e
5 0000 00 00
4 0040 00 00
2 7ffd 0f 00
0 c000 ab 00
0 c001 cd 00
1 c000 00 ab
1 4000 00 11
5 0000 00 00
4 0040 00 00
6 0000 00 00
2 7ffd 20 00
1 0000 00 80
2 7ffd 17 00
1 0000 00 80
1 c005 00 9a
3 7ffd 00 ff
3 00fe 00 ff

// ==== list.f ====
+incdir+hw
hw/zx_pkg.sv
hw/page_regs.sv
hw/zmem.sv
hw/arbiter.sv
hw/dram_store.sv
hw/vfetch.sv
hw/zx_mem_top.sv
tb/zx_mem_props.sv
tb/tb_zx_mem.sv

// ==== Bender.yml ====
package:
  name: zx_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/zx_pkg.sv
      - hw/page_regs.sv
      - hw/zmem.sv
      - hw/arbiter.sv
      - hw/dram_store.sv
      - hw/vfetch.sv
      - hw/zx_mem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/zx_mem_props.sv
      - tb/tb_zx_mem.sv
